// ==== src/axi_pkg.sv ====
/*
 * AXI4 definitions for the core memory port
 * address, data, strobe and ID types
 * ID values, response codes and burst code
 * channel payload structs for AW/AR, W, B and R
 */

package axi_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [7:0]  strb_t;
	typedef logic [4:0]  axi_id_t;

	// core traffic vs core-local devices
	localparam axi_id_t id_core = 5'd1;
	localparam axi_id_t id_io   = 5'd2;

	typedef logic [1:0] resp_t;

	localparam resp_t resp_okay   = 2'b00;
	localparam resp_t resp_slverr = 2'b10;

	localparam logic [1:0] burst_incr = 2'b01;

	// shared by AW and AR
	typedef struct packed {
		axi_id_t    id;
		addr_t      addr;
		logic [7:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} axi_ax_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
		logic  last;
	} axi_w_t;

	typedef struct packed {
		axi_id_t id;
		resp_t   resp;
	} axi_b_t;

	typedef struct packed {
		axi_id_t id;
		data_t   data;
		resp_t   resp;
		logic    last;
	} axi_r_t;

endpackage

// ==== src/core_mem_pkg.sv ====
/*
 * core-side memory request and response types
 * fetch request, load/store request and response
 * size code for a full 64-bit access
 */

package core_mem_pkg;

	// 8-byte access
	localparam logic [2:0] size_dword = 3'd3;

	typedef struct packed {
		axi_pkg::addr_t addr;
	} fetch_req_t;

	// io marks core-local device accesses
	typedef struct packed {
		axi_pkg::addr_t addr;
		axi_pkg::data_t wdata;
		axi_pkg::strb_t wmask;
		logic [2:0]     size;
		logic           io;
	} lsu_req_t;

	typedef struct packed {
		axi_pkg::data_t rdata;
		logic           err;
	} lsu_rsp_t;

endpackage

// ==== src/axi_master_arbiter.sv ====
/*
 * AXI4 master arbiter
 * fetch and load/store requests share one master port
 * read FSM with fetch priority, write FSM runs on its own
 * single-beat transfers, error reported back to the LSU
 */

`timescale 1ns/1ps

module axi_master_arbiter (
	input  logic                     clk,
	input  logic                     rst,

	input  logic                     fetch_ena,
	input  core_mem_pkg::fetch_req_t fetch_req,
	output axi_pkg::data_t           fetch_inst,
	output logic                     fetch_valid,

	input  logic                     lsu_re,
	input  logic                     lsu_we,
	input  core_mem_pkg::lsu_req_t   lsu_req,
	output core_mem_pkg::lsu_rsp_t   lsu_rsp,
	output logic                     lsu_valid,

	output axi_pkg::axi_ax_t         ar,
	output logic                     ar_valid,
	input  logic                     ar_ready,
	output axi_pkg::axi_ax_t         aw,
	output logic                     aw_valid,
	input  logic                     aw_ready,
	output axi_pkg::axi_w_t          w,
	output logic                     w_valid,
	input  logic                     w_ready,
	input  axi_pkg::axi_b_t          b,
	input  logic                     b_valid,
	output logic                     b_ready,
	input  axi_pkg::axi_r_t          r,
	input  logic                     r_valid,
	output logic                     r_ready
);
	import axi_pkg::*;
	import core_mem_pkg::*;

	typedef enum logic [1:0] {rd_idle, rd_addr, rd_read} rd_state_t;
	typedef enum logic [1:0] {wr_idle, wr_addr, wr_write, wr_resp} wr_state_t;

	rd_state_t rd_state;
	wr_state_t wr_state;
	logic      rd_fetch;
	axi_id_t   rd_id;
	axi_id_t   wr_id;
	logic      aw_done;

	logic ar_hs;
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	logic r_hs;
	logic rd_done;
	logic wr_done;

	assign ar_hs   = ar_valid & ar_ready;
	assign aw_hs   = aw_valid & aw_ready;
	assign w_hs    = w_valid & w_ready & w.last;
	assign b_hs    = b_valid & b_ready;
	assign r_hs    = r_valid & r_ready & r.last;
	assign rd_done = (rd_state == rd_read) & r_hs;
	assign wr_done = (wr_state == wr_resp) & b_hs;

	// reads, one at a time, fetch wins
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= rd_idle;
			rd_fetch <= 1'b0;
			rd_id    <= id_core;
		end else begin
			case (rd_state)
				rd_idle: begin
					if (fetch_ena | lsu_re) begin
						rd_state <= rd_addr;
						rd_fetch <= fetch_ena;
						rd_id    <= (!fetch_ena && lsu_req.io) ? id_io : id_core;
					end
				end
				rd_addr: begin
					if (ar_hs) begin
						rd_state <= rd_read;
					end
				end
				rd_read: begin
					if (r_hs) begin
						rd_state <= rd_idle;
					end
				end
				default: rd_state <= rd_idle;
			endcase
		end
	end

	// writes, aw and w raised together
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= wr_idle;
			wr_id    <= id_core;
			aw_done  <= 1'b0;
		end else begin
			if (aw_hs) begin
				aw_done <= 1'b1;
			end
			case (wr_state)
				wr_idle: begin
					aw_done <= 1'b0;
					if (lsu_we) begin
						wr_state <= wr_addr;
						wr_id    <= lsu_req.io ? id_io : id_core;
					end
				end
				wr_addr: begin
					if (w_hs) begin
						wr_state <= wr_resp;
					end else if (aw_hs) begin
						wr_state <= wr_write;
					end
				end
				wr_write: begin
					if (w_hs) begin
						wr_state <= wr_resp;
					end
				end
				wr_resp: begin
					if (b_hs) begin
						wr_state <= wr_idle;
					end
				end
				default: wr_state <= wr_idle;
			endcase
		end
	end

	always_comb begin
		ar.id    = rd_id;
		ar.addr  = rd_fetch ? fetch_req.addr : lsu_req.addr;
		ar.len   = 8'd0;
		ar.size  = rd_fetch ? size_dword : lsu_req.size;
		ar.burst = burst_incr;

		aw.id    = wr_id;
		aw.addr  = lsu_req.addr;
		aw.len   = 8'd0;
		aw.size  = lsu_req.size;
		aw.burst = burst_incr;

		w.data = lsu_req.wdata;
		w.strb = lsu_req.wmask;
		w.last = 1'b1;
	end

	assign ar_valid = (rd_state == rd_addr);
	// aw may still be owed if w went first
	assign aw_valid = (wr_state == wr_addr) | ((wr_state == wr_resp) & ~aw_done);
	assign w_valid  = (wr_state == wr_addr) | (wr_state == wr_write);
	assign b_ready  = 1'b1;
	assign r_ready  = 1'b1;

	assign fetch_inst  = r.data;
	assign fetch_valid = rd_done & rd_fetch;
	assign lsu_valid   = (rd_done & ~rd_fetch) | wr_done;

	// a fetch may finish alongside a store response
	always_comb begin
		lsu_rsp.rdata = r.data;
		lsu_rsp.err   = (rd_done & ~rd_fetch) ? (r.resp != resp_okay) : (b.resp != resp_okay);
	end

	a_lsu_one_dir: assert property (@(posedge clk) disable iff (rst)
		!(lsu_re && lsu_we));

	a_r_id: assert property (@(posedge clk) disable iff (rst)
		(rd_state == rd_read && r_valid) |-> (r.id == rd_id));

	a_b_id: assert property (@(posedge clk) disable iff (rst)
		b_valid |-> (b.id == wr_id));

	// requester must hold its address too
	a_ar_hold: assert property (@(posedge clk) disable iff (rst)
		(ar_valid && !ar_ready) |=> (ar_valid && $stable(ar)));

endmodule

// ==== src/axi_sram_slave.sv ====
/*
 * single-beat AXI4 SRAM slave model
 * word storage with byte strobes on write
 * configurable read latency, one read in flight
 * SLVERR for addresses past the end of the array
 */

`timescale 1ns/1ps

module axi_sram_slave #(
	parameter int mem_words    = 1024,
	parameter int read_latency = 2
) (
	input  logic             clk,
	input  logic             rst,

	input  axi_pkg::axi_ax_t ar,
	input  logic             ar_valid,
	output logic             ar_ready,
	input  axi_pkg::axi_ax_t aw,
	input  logic             aw_valid,
	output logic             aw_ready,
	input  axi_pkg::axi_w_t  w,
	input  logic             w_valid,
	output logic             w_ready,
	output axi_pkg::axi_b_t  b,
	output logic             b_valid,
	input  logic             b_ready,
	output axi_pkg::axi_r_t  r,
	output logic             r_valid,
	input  logic             r_ready
);
	import axi_pkg::*;

	localparam int    idx_w     = $clog2(mem_words);
	localparam addr_t mem_bytes = addr_t'(mem_words * 8);

	data_t mem [mem_words];

	logic             rd_busy;
	logic [7:0]       rd_cnt;
	axi_id_t          rd_id;
	addr_t            rd_addr;
	logic             rd_ok;
	logic [idx_w-1:0] rd_idx;

	logic             wr_fire;
	logic             wr_ok;
	logic [idx_w-1:0] wr_idx;

	// read side
	assign ar_ready = ~rd_busy;
	assign r_valid  = rd_busy & (rd_cnt == 8'd0);
	assign rd_ok    = rd_addr < mem_bytes;
	assign rd_idx   = rd_addr[idx_w+2:3];

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_busy <= 1'b0;
			rd_cnt  <= 8'd0;
		end else if (ar_valid && ar_ready) begin
			rd_busy <= 1'b1;
			rd_cnt  <= 8'(read_latency);
		end else if (r_valid && r_ready) begin
			rd_busy <= 1'b0;
		end else if (rd_busy && rd_cnt != 8'd0) begin
			rd_cnt <= rd_cnt - 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_valid && ar_ready) begin
			rd_id   <= ar.id;
			rd_addr <= ar.addr;
		end
	end

	// word read when the beat goes out
	always_comb begin
		r.id   = rd_id;
		r.data = rd_ok ? mem[rd_idx] : '0;
		r.resp = rd_ok ? resp_okay : resp_slverr;
		r.last = 1'b1;
	end

	// write side, aw and w taken in one cycle
	assign aw_ready = ~b_valid;
	assign w_ready  = ~b_valid;
	assign wr_fire  = aw_valid & aw_ready & w_valid & w_ready;
	assign wr_ok    = aw.addr < mem_bytes;
	assign wr_idx   = aw.addr[idx_w+2:3];

	always_ff @(posedge clk) begin
		if (wr_fire && wr_ok) begin
			for (int i = 0; i < 8; i++) begin
				if (w.strb[i]) begin
					mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			b_valid <= 1'b0;
		end else if (wr_fire) begin
			b_valid <= 1'b1;
		end else if (b_ready) begin
			b_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			b.id   <= aw.id;
			b.resp <= wr_ok ? resp_okay : resp_slverr;
		end
	end

	// master only ever sends single beats
	a_w_last: assert property (@(posedge clk) disable iff (rst)
		(w_valid && w_ready) |-> w.last);

endmodule

// ==== src/mem_subsys_top.sv ====
/*
 * memory subsystem top level
 * arbiter on the core side, SRAM slave behind it
 */

`timescale 1ns/1ps

module mem_subsys_top #(
	parameter int mem_words    = 1024,
	parameter int read_latency = 2
) (
	input  logic                     clk,
	input  logic                     rst,

	input  logic                     fetch_ena,
	input  core_mem_pkg::fetch_req_t fetch_req,
	output axi_pkg::data_t           fetch_inst,
	output logic                     fetch_valid,

	input  logic                     lsu_re,
	input  logic                     lsu_we,
	input  core_mem_pkg::lsu_req_t   lsu_req,
	output core_mem_pkg::lsu_rsp_t   lsu_rsp,
	output logic                     lsu_valid
);
	import axi_pkg::*;

	axi_ax_t ar;
	logic    ar_valid;
	logic    ar_ready;
	axi_ax_t aw;
	logic    aw_valid;
	logic    aw_ready;
	axi_w_t  w;
	logic    w_valid;
	logic    w_ready;
	axi_b_t  b;
	logic    b_valid;
	logic    b_ready;
	axi_r_t  r;
	logic    r_valid;
	logic    r_ready;

	axi_master_arbiter arb0 (
		.clk         (clk),
		.rst         (rst),
		.fetch_ena   (fetch_ena),
		.fetch_req   (fetch_req),
		.fetch_inst  (fetch_inst),
		.fetch_valid (fetch_valid),
		.lsu_re      (lsu_re),
		.lsu_we      (lsu_we),
		.lsu_req     (lsu_req),
		.lsu_rsp     (lsu_rsp),
		.lsu_valid   (lsu_valid),
		.ar          (ar),
		.ar_valid    (ar_valid),
		.ar_ready    (ar_ready),
		.aw          (aw),
		.aw_valid    (aw_valid),
		.aw_ready    (aw_ready),
		.w           (w),
		.w_valid     (w_valid),
		.w_ready     (w_ready),
		.b           (b),
		.b_valid     (b_valid),
		.b_ready     (b_ready),
		.r           (r),
		.r_valid     (r_valid),
		.r_ready     (r_ready)
	);

	axi_sram_slave #(
		.mem_words    (mem_words),
		.read_latency (read_latency)
	) mem0 (
		.clk      (clk),
		.rst      (rst),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.aw       (aw),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.w        (w),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.b        (b),
		.b_valid  (b_valid),
		.b_ready  (b_ready),
		.r        (r),
		.r_valid  (r_valid),
		.r_ready  (r_ready)
	);

endmodule

// ==== dv/tb_mem_tasks.svh ====
/*
 * value check, per-test report and directed tests
 * included inside the testbench module
 */

task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
	checks++;
	if (got !== expected) begin
		errors++;
		$display("MISMATCH %s got %h expected %h", name, got, expected);
	end
endtask

task automatic finish_test(input string name);
	$display("test %s finished, %0d errors", name, errors - test_err_base);
	test_err_base = errors;
	tests++;
endtask

task automatic test_store_load();
	store(32'h0000_0040, {$urandom, $urandom}, 8'hff, 1'b0);
	load(32'h0000_0040, 1'b0);
	finish_test("store_load");
endtask

task automatic test_partial_store();
	store(32'h0000_0048, {$urandom, $urandom}, 8'b1010_0101, 1'b0);
	store(32'h0000_0050, {$urandom, $urandom}, 8'b0001_1000, 1'b0);
	load(32'h0000_0048, 1'b0);
	load(32'h0000_0050, 1'b0);
	finish_test("partial_store");
endtask

task automatic test_fetch_sees_stores();
	for (int i = 0; i < 4; i++) begin
		store(addr_t'(32'h60 + i * 8), {$urandom, $urandom}, 8'hff, 1'b0);
	end
	for (int i = 0; i < 4; i++) begin
		fetch(addr_t'(32'h60 + i * 8));
	end
	finish_test("fetch_sees_stores");
endtask

// fetch and load raised on the same edge
task automatic test_contention();
	int fetch_at;
	int lsu_at;
	fetch_at = -1;
	lsu_at = -1;
	fetch_req.addr = 32'h0000_0010;
	lsu_req = '{addr: 32'h0000_0018, wdata: 64'd0, wmask: 8'd0, size: size_dword, io: 1'b0};
	fetch_ena = 1'b1;
	lsu_re = 1'b1;
	while (fetch_at < 0 || lsu_at < 0) begin
		@(negedge clk);
		if (fetch_ena && fetch_valid) begin
			fetch_at = cycles;
			check_value("fetch_inst", fetch_inst, ref_mem[2]);
			fetch_ena = 1'b0;
		end
		if (lsu_re && lsu_valid) begin
			lsu_at = cycles;
			check_value("lsu_rsp.rdata", lsu_rsp.rdata, ref_mem[3]);
			lsu_re = 1'b0;
		end
	end
	if (fetch_at > lsu_at) begin
		errors++;
		$display("the load finished before the fetch that should have won");
	end
	finish_test("contention");
endtask

// 0x2000 aliases word 0 if the range check is missing
task automatic test_out_of_range();
	load(32'h0000_2000, 1'b0);
	store(32'h0000_2000, {$urandom, $urandom}, 8'hff, 1'b0);
	load(32'h0000_0000, 1'b0);
	load(32'h0000_2000, 1'b1);
	store(32'h0000_2008, {$urandom, $urandom}, 8'hff, 1'b1);
	finish_test("out_of_range");
endtask

task automatic test_random_mix();
	int    op;
	addr_t addr;
	logic  io;
	repeat (200) begin
		op = $urandom_range(2, 0);
		addr = addr_t'($urandom_range(test_words - 1, 0) << 3);
		io = ($urandom_range(1, 0) != 0);
		case (op)
			0: store(addr, {$urandom, $urandom}, strb_t'($urandom), io);
			1: load(addr, io);
			default: fetch(addr);
		endcase
	end
	finish_test("random_mix");
endtask

// ==== dv/tb_mem_subsys.sv ====
/*
 * testbench for the memory subsystem
 * clock, reset, DUT and reference memory
 * request drivers, timeout and test sequence
 */

`timescale 1ns/1ps

module tb_mem_subsys;
	import axi_pkg::*;
	import core_mem_pkg::*;

	localparam int mem_words  = 1024;
	localparam int idx_w      = $clog2(mem_words);
	localparam int test_words = 32;
	localparam int max_cycles = 6000;

	logic       clk;
	logic       rst;
	logic       fetch_ena;
	fetch_req_t fetch_req;
	data_t      fetch_inst;
	logic       fetch_valid;
	logic       lsu_re;
	logic       lsu_we;
	lsu_req_t   lsu_req;
	lsu_rsp_t   lsu_rsp;
	logic       lsu_valid;

	data_t       ref_mem [mem_words];
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          test_err_base = 0;
	int unsigned seed;

	mem_subsys_top #(
		.mem_words    (mem_words),
		.read_latency (2)
	) dut0 (.*);

	`include "tb_mem_tasks.svh"

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles, a request never completed", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic in_range(input addr_t addr);
		return addr < addr_t'(mem_words * 8);
	endfunction

	function automatic logic [idx_w-1:0] word_of(input addr_t addr);
		return addr[idx_w+2:3];
	endfunction

	// all drivers start and end on a falling edge
	task automatic store(input addr_t addr, input data_t data, input strb_t mask,
			input logic io);
		lsu_req = '{addr: addr, wdata: data, wmask: mask, size: size_dword, io: io};
		lsu_we = 1'b1;
		@(negedge clk);
		while (!lsu_valid) @(negedge clk);
		check_value("lsu_rsp.err", 64'(lsu_rsp.err), 64'(!in_range(addr)));
		lsu_we = 1'b0;
		if (in_range(addr)) begin
			for (int i = 0; i < 8; i++) begin
				if (mask[i]) begin
					ref_mem[word_of(addr)][8*i +: 8] = data[8*i +: 8];
				end
			end
		end
	endtask

	task automatic load(input addr_t addr, input logic io);
		data_t expected;
		expected = in_range(addr) ? ref_mem[word_of(addr)] : 64'd0;
		lsu_req = '{addr: addr, wdata: 64'd0, wmask: 8'd0, size: size_dword, io: io};
		lsu_re = 1'b1;
		@(negedge clk);
		while (!lsu_valid) @(negedge clk);
		check_value("lsu_rsp.rdata", lsu_rsp.rdata, expected);
		check_value("lsu_rsp.err", 64'(lsu_rsp.err), 64'(!in_range(addr)));
		lsu_re = 1'b0;
	endtask

	task automatic fetch(input addr_t addr);
		fetch_req.addr = addr;
		fetch_ena = 1'b1;
		@(negedge clk);
		while (!fetch_valid) @(negedge clk);
		check_value("fetch_inst", fetch_inst, ref_mem[word_of(addr)]);
		fetch_ena = 1'b0;
	endtask

	// pattern from the full byte address
	task automatic fill_memory();
		addr_t a;
		for (int i = 0; i < test_words; i++) begin
			a = addr_t'(i * 8);
			store(a, {~a, a}, 8'hff, 1'b0);
		end
		finish_test("fill_memory");
	endtask

	initial begin
		seed = $urandom(32'h2c2a);
		rst = 1'b1;
		fetch_ena = 1'b0;
		fetch_req = '0;
		lsu_re = 1'b0;
		lsu_we = 1'b0;
		lsu_req = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		fill_memory();
		test_store_load();
		test_partial_store();
		test_fetch_sees_stores();
		test_contention();
		test_out_of_range();
		test_random_mix();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+dv
src/axi_pkg.sv
src/core_mem_pkg.sv
src/axi_master_arbiter.sv
src/axi_sram_slave.sv
src/mem_subsys_top.sv
dv/tb_mem_subsys.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module tb_mem_subsys -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
	echo "no result line in $LOG"
	exit 1
fi
exit 0
